// ==== sources.f ====
+incdir+.
apb_pkg.sv
cache_pkg.sv
refill_counter.sv
cache_tag_array.sv
cache_data_array.sv
cache_replacement_policy.sv
cache_ctrl_fsm.sv
apb_cache.sv
tb_apb_cache.sv

// ==== Makefile ====
TOOL     ?= verilator
FLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
TOP      ?= tb_apb_cache
RTL_TOP  ?= apb_cache
FILELIST ?= sources.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || { echo "simulation did not finish"; exit 1; }

lint:
	$(TOOL) --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb_apb_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module tb_apb_cache import apb_pkg::*; import cache_pkg::*; ();

   localparam int XFER_TIMEOUT = 200;   // cycles per APB transfer
   localparam int N_RANDOM     = 300;

   logic      clk_i;
   logic      reset_i;
   apb_req_t  apb_req;
   apb_resp_t apb_rsp;
   mem_req_t  mem_req;
   mem_resp_t mem_rsp = '0;

   logic [15:0] stim_lfsr = 16'd12;
   logic [15:0] mem_lfsr  = 16'd12;   // separate stream for ack delays
   word_t       mem_words [addr_t];   // sparse backing memory
   mem_req_t    mem_log [$];          // requests acked in the current transfer
   mem_req_t    req_s;                // request seen at the falling edge
   int          mem_wait;
   int          n_checks;
   int          n_errors;
   logic        hung;

   // reference cache state
   logic [N_WAYS-1:0] mdl_valid [N_LINES];
   tag_t              mdl_tag   [N_LINES][N_WAYS];
   logic [N_WAYS-2:0] mdl_tree  [N_LINES];   // heap order with the root at bit 0

   apb_cache apb_cache_inst (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .apb_i      (apb_req),
      .apb_o      (apb_rsp),
      .mem_req_o  (mem_req),
      .mem_resp_i (mem_rsp)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic draw_bits(inout logic [15:0] s, input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         s = lfsr_step(s);   // one step per bit
         v = {v[14:0], s[0]};
      end
   endtask

   function automatic word_t fill_word(input addr_t a);
      return word_t'({a ^ 16'h3c5a, ~a});
   endfunction

   function automatic word_t mem_word(input addr_t a);
      return mem_words.exists(a) ? mem_words[a] : fill_word(a);
   endfunction

   function automatic addr_t make_addr(input tag_t t, input line_idx_t l, input word_idx_t w);
      addr_fields_t f;
      f          = '0;
      f.tag      = t;
      f.line     = l;
      f.word     = w;
      return addr_t'(f);
   endfunction

   function automatic int model_find(input addr_fields_t f);
      for (int w = 0; w < N_WAYS; w++) begin
         if (mdl_valid[f.line][w] && mdl_tag[f.line][w] == f.tag) return w;
      end
      return -1;   // miss
   endfunction

   // follow node bits from the root where 0 is left
   function automatic int model_victim(input line_idx_t l);
      int node;
      node = 1;
      for (int i = 0; i < WAY_W; i++) begin
         node = 2 * node + int'(mdl_tree[l][node-1]);
      end
      return node - N_WAYS;
   endfunction

   function automatic void model_touch(input line_idx_t l, input int way);
      int   node;
      logic b;
      node = 1;
      for (int i = 0; i < WAY_W; i++) begin
         b                  = way[WAY_W-1-i];
         mdl_tree[l][node-1] = ~b;   // point away from the hit way
         node               = 2 * node + int'(b);
      end
   endfunction

   function automatic void model_reset();
      for (int l = 0; l < N_LINES; l++) begin
         mdl_valid[l] = '0;
         mdl_tree[l]  = '0;
      end
   endfunction

   // memory responder acks 1 to 4 cycles after the request
   always @(negedge clk_i) req_s = mem_req;

   always @(posedge clk_i) begin : responder
      logic [15:0] d;
      if (reset_i) begin
         mem_rsp  <= '0;
         mem_wait = -1;
      end else if (mem_rsp.ack) begin
         mem_rsp.ack <= 1'b0;   // word completed at this edge
         mem_wait    = -1;
      end else if (req_s.valid) begin
         if (mem_wait < 0) begin
            draw_bits(mem_lfsr, 2, d);
            mem_wait = int'(d);
         end
         if (mem_wait == 0) begin
            mem_rsp.ack <= 1'b1;
            if (req_s.we) mem_words[req_s.addr] = req_s.wdata;
            else          mem_rsp.rdata <= mem_word(req_s.addr);
            mem_log.push_back(req_s);
         end else begin
            mem_wait--;
         end
      end
   end

   task automatic note_failure(input string msg);
      n_errors++;
      $display("error: %s", msg);
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   // read wdata is don't care
   task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
      n_checks++;
      if (got.valid !== exp.valid || got.we !== exp.we || got.addr !== exp.addr ||
          (exp.we && got.wdata !== exp.wdata)) begin
         n_errors++;
         $display("** Error: mem_req_o got 0x%h expected 0x%h", got, exp);
      end
   endtask

   task automatic check_resp_err(input apb_resp_t got, input logic exp_err);
      n_checks++;
      if (got.pslverr !== exp_err) begin
         n_errors++;
         $display("** Error: apb_o.pslverr got 0x%h expected 0x%h", got.pslverr, exp_err);
      end
   endtask

   task automatic check_idle(input apb_resp_t rsp, input mem_req_t req);
      n_checks++;
      if (rsp.pready !== 1'b0 || rsp.pslverr !== 1'b0 || req.valid !== 1'b0) begin
         n_errors++;
         $display("** Error: apb_o.pready/pslverr/mem_req_o.valid got 0x%h/0x%h/0x%h expected 0x0",
                  rsp.pready, rsp.pslverr, req.valid);
      end
   endtask

   task automatic apb_xfer(input logic wr, input addr_t a, input word_t wd,
                           output apb_resp_t resp, output int waits, output logic ok);
      resp  = '0;
      waits = 0;
      ok    = 1'b0;
      if (hung) return;
      mem_log.delete();
      @(posedge clk_i);
      apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: a, pwdata: wd};   // setup
      @(posedge clk_i);
      apb_req.penable <= 1'b1;
      @(negedge clk_i);
      while (!apb_rsp.pready && waits < XFER_TIMEOUT) begin
         @(negedge clk_i);
         waits++;
      end
      if (!apb_rsp.pready) begin
         note_failure($sformatf("transfer to 0x%h saw no pready within %0d cycles",
                                a, XFER_TIMEOUT));
         hung = 1'b1;
         return;
      end
      resp = apb_rsp;
      ok   = 1'b1;
      @(posedge clk_i);
      apb_req <= '0;
   endtask

   task automatic do_read(input addr_t a);
      addr_fields_t f;
      apb_resp_t    r;
      mem_req_t     exp;
      int           way;
      int           waits;
      logic         ok;
      f   = addr_fields_t'(a);
      way = model_find(f);
      apb_xfer(1'b0, a, '0, r, waits, ok);
      if (!ok) return;
      check_resp_err(r, 1'b0);
      check_word("apb_o.prdata", r.prdata, mem_word(a));
      if (way >= 0) begin
         if (mem_log.size() != 0)
            note_failure($sformatf("read hit at 0x%h made %0d memory requests",
                                   a, mem_log.size()));
         if (waits != 0)
            note_failure($sformatf("read hit at 0x%h took %0d wait states", a, waits));
      end else if (mem_log.size() != LINE_WORDS) begin
         note_failure($sformatf("read miss at 0x%h made %0d memory requests, not %0d",
                                a, mem_log.size(), LINE_WORDS));
      end else begin
         for (int i = 0; i < LINE_WORDS; i++) begin
            exp = '{valid: 1'b1, we: 1'b0, addr: make_addr(f.tag, f.line, word_idx_t'(i)),
                    wdata: '0};   // line base upward
            check_mem_req(mem_log[i], exp);
         end
      end
      if (way < 0) begin
         way                  = model_victim(f.line);
         mdl_valid[f.line][way] = 1'b1;
         mdl_tag[f.line][way]   = f.tag;
      end
      model_touch(f.line, way);   // the lookup after a refill hits as well
   endtask

   task automatic do_write(input addr_t a, input word_t d);
      addr_fields_t f;
      apb_resp_t    r;
      mem_req_t     exp;
      int           way;
      int           waits;
      logic         ok;
      f   = addr_fields_t'(a);
      way = model_find(f);
      apb_xfer(1'b1, a, d, r, waits, ok);
      if (!ok) return;
      check_resp_err(r, 1'b0);
      if (mem_log.size() != 1) begin
         note_failure($sformatf("write to 0x%h made %0d memory requests, not 1",
                                a, mem_log.size()));
      end else begin
         exp = '{valid: 1'b1, we: 1'b1, addr: a, wdata: d};
         check_mem_req(mem_log[0], exp);
      end
      if (way >= 0) model_touch(f.line, way);   // no allocate on a miss
   endtask

   task automatic do_misaligned(input logic wr, input addr_t a, input word_t d);
      apb_resp_t r;
      int        waits;
      logic      ok;
      apb_xfer(wr, a, d, r, waits, ok);
      if (!ok) return;
      check_resp_err(r, 1'b1);
      if (waits != 0)
         note_failure($sformatf("misaligned access at 0x%h took %0d wait states", a, waits));
      if (mem_log.size() != 0)
         note_failure($sformatf("misaligned access at 0x%h reached memory", a));
   endtask

   task automatic apply_reset();
      reset_i <= 1'b1;
      apb_req <= '0;
      repeat (5) @(posedge clk_i);
      reset_i <= 1'b0;
      model_reset();
      @(negedge clk_i);
      check_idle(apb_rsp, mem_req);
   endtask

   task automatic report_test(input string name, input int err_start);
      $display("test %-14s %s, %0d errors", name,
               (n_errors == err_start) ? "ok" : "FAILED", n_errors - err_start);
   endtask

   initial begin
      logic [15:0] v;
      logic [15:0] v2;
      logic [3:0]  kind;
      addr_t       a;
      int          err0;
      int          vic;
      tag_t        ev_tag;
      n_checks = 0;
      n_errors = 0;
      hung     = 1'b0;

      err0 = n_errors;
      apply_reset();
      report_test("reset", err0);

      // fill set 6 and let a fifth tag push out the tree victim
      err0 = n_errors;
      for (int t = 0; t < N_WAYS; t++) do_read(make_addr(tag_t'(8 + t), 3'd6, 2'd0));
      vic    = model_victim(3'd6);
      ev_tag = mdl_tag[6][vic];
      do_read(make_addr(tag_t'(12), 3'd6, 2'd1));
      for (int t = 8; t < 12; t++) begin
         if (tag_t'(t) != ev_tag) do_read(make_addr(tag_t'(t), 3'd6, 2'd2));   // still resident
      end
      do_read(make_addr(ev_tag, 3'd6, 2'd3));   // misses again
      report_test("eviction", err0);

      err0 = n_errors;
      do_write(make_addr(tag_t'(9), 3'd6, 2'd1), 32'hcafe_0001);    // write hit
      do_read(make_addr(tag_t'(9), 3'd6, 2'd1));
      do_write(make_addr(tag_t'(3), 3'd7, 2'd2), 32'hcafe_0002);    // write miss
      do_read(make_addr(tag_t'(3), 3'd7, 2'd2));
      do_read(make_addr(tag_t'(3), 3'd7, 2'd2));
      report_test("write_through", err0);

      err0 = n_errors;
      do_misaligned(1'b0, make_addr(tag_t'(8), 3'd6, 2'd0) | 16'h1, '0);
      do_misaligned(1'b1, make_addr(tag_t'(1), 3'd0, 2'd3) | 16'h2, 32'h0bad_0bad);
      do_misaligned(1'b0, 16'h0013, '0);
      report_test("misaligned", err0);

      // 12 lines over sets 0 and 1 compete for 8 ways
      err0 = n_errors;
      for (int i = 0; i < N_RANDOM; i++) begin
         draw_bits(stim_lfsr, 4, v);
         kind = v[3:0];
         draw_bits(stim_lfsr, 3, v);
         draw_bits(stim_lfsr, 3, v2);
         a = make_addr(tag_t'(v % 6), line_idx_t'(v2[0]), word_idx_t'(v2[2:1]));
         if (kind < 4'd3) begin
            draw_bits(stim_lfsr, 16, v);
            draw_bits(stim_lfsr, 16, v2);
            do_write(a, {v, v2});
         end else if (kind == 4'd3) begin
            draw_bits(stim_lfsr, 3, v);
            a[1:0] = (v[1:0] == 2'd0) ? 2'd2 : v[1:0];   // never aligned
            do_misaligned(v[2], a, 32'h1234_5678);
         end else begin
            do_read(a);
         end
      end
      report_test("random_ops", err0);

      // cached line from before must miss after reset
      err0 = n_errors;
      @(posedge clk_i);
      apply_reset();
      do_read(make_addr(tag_t'(9), 3'd6, 2'd1));
      do_read(make_addr(tag_t'(9), 3'd6, 2'd0));
      report_test("reset_again", err0);

      $display("%0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== apb_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module apb_cache import apb_pkg::*; import cache_pkg::*; (
   input  logic      clk_i,
   input  logic      reset_i,
   input  apb_req_t  apb_i,
   output apb_resp_t apb_o,
   output mem_req_t  mem_req_o,
   input  mem_resp_t mem_resp_i
);

   addr_fields_t lookup_addr;    // shared lookup address, split for the policy
   lookup_t      lookup;
   word_t        rdata;
   way_vec_t     victim;
   data_wr_t     data_wr;
   word_idx_t    word_idx;
   logic         fill;
   logic         policy_update;
   logic         refill_start;
   logic         refill_step;
   logic         last;

   cache_ctrl_fsm ctrl_inst (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .apb_i           (apb_i),
      .apb_o           (apb_o),
      .mem_req_o       (mem_req_o),
      .mem_resp_i      (mem_resp_i),
      .lookup_i        (lookup),
      .lookup_addr_o   (lookup_addr),
      .rdata_i         (rdata),
      .fill_o          (fill),
      .victim_i        (victim),
      .data_wr_o       (data_wr),
      .policy_update_o (policy_update),
      .refill_start_o  (refill_start),
      .refill_step_o   (refill_step),
      .word_idx_i      (word_idx),
      .last_i          (last)
   );

   refill_counter refill_cnt_inst (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .start_i    (refill_start),
      .step_i     (refill_step),
      .word_idx_o (word_idx),
      .last_o     (last)
   );

   cache_tag_array tag_inst (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .addr_i     (lookup_addr),
      .fill_i     (fill),
      .fill_way_i (victim),      // policy holds still during a refill
      .lookup_o   (lookup)
   );

   cache_data_array data_inst (
      .clk_i    (clk_i),
      .addr_i   (lookup_addr),
      .rd_way_i (lookup.way),
      .rdata_o  (rdata),
      .wr_i     (data_wr)
   );

   cache_replacement_policy #(
      .REP_POLICY (`CACHE_REP_POLICY)
   ) policy_inst (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .update_i  (policy_update),
      .line_i    (lookup_addr.line),
      .way_hit_i (lookup.way),
      .victim_o  (victim)
   );

endmodule

`default_nettype wire

// ==== cache_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl_fsm import apb_pkg::*; import cache_pkg::*; (
   input  logic      clk_i,
   input  logic      reset_i,
   input  apb_req_t  apb_i,
   output apb_resp_t apb_o,
   output mem_req_t  mem_req_o,
   input  mem_resp_t mem_resp_i,
   input  lookup_t   lookup_i,
   output addr_t     lookup_addr_o,
   input  word_t     rdata_i,           // cached word of the hit way
   output logic      fill_o,
   input  way_vec_t  victim_i,
   output data_wr_t  data_wr_o,
   output logic      policy_update_o,
   output logic      refill_start_o,
   output logic      refill_step_o,
   input  word_idx_t word_idx_i,
   input  logic      last_i
);

   ctrl_state_e  state_q, state_d;
   way_vec_t     victim_q;   // way under refill
   addr_fields_t req_f;      // APB address, held stable by the requester
   addr_fields_t refill_f;   // current refill word address

   assign req_f         = addr_fields_t'(apb_i.paddr);
   assign lookup_addr_o = apb_i.paddr;

   always_comb begin
      refill_f          = req_f;
      refill_f.word     = word_idx_i;   // ascending from the line base
      refill_f.byte_off = '0;
   end

   always_comb begin
      state_d         = state_q;
      apb_o           = '0;
      mem_req_o       = '0;
      data_wr_o       = '0;
      fill_o          = 1'b0;
      policy_update_o = 1'b0;
      refill_start_o  = 1'b0;
      refill_step_o   = 1'b0;
      case (state_q)
         ST_IDLE: begin
            if (apb_i.psel && !apb_i.penable) begin   // setup cycle
               if (req_f.byte_off != '0) state_d = ST_ERROR;
               else if (apb_i.pwrite)    state_d = ST_WRITE;
               else                      state_d = ST_LOOKUP;
            end
         end
         ST_LOOKUP: begin
            if (apb_i.pwrite) begin              // write already done in memory
               apb_o.pready = 1'b1;
               state_d      = ST_IDLE;
            end else if (lookup_i.hit) begin
               apb_o.pready    = 1'b1;
               apb_o.prdata    = rdata_i;
               policy_update_o = 1'b1;
               state_d         = ST_IDLE;
            end else begin
               refill_start_o = 1'b1;
               state_d        = ST_REFILL;
            end
         end
         ST_REFILL: begin
            mem_req_o.valid = 1'b1;
            mem_req_o.addr  = refill_f;
            if (mem_resp_i.ack) begin
               refill_step_o = 1'b1;
               data_wr_o     = '{en: 1'b1, way: victim_q, line: req_f.line,
                                 word: word_idx_i, data: mem_resp_i.rdata};
               if (last_i) begin
                  fill_o  = 1'b1;          // tag and valid with the last word
                  state_d = ST_LOOKUP;     // lookup again, now a hit
               end
            end
         end
         ST_WRITE: begin
            mem_req_o = '{valid: 1'b1, we: 1'b1, addr: apb_i.paddr, wdata: apb_i.pwdata};
            if (mem_resp_i.ack) begin
               if (lookup_i.hit) begin     // keep the cached copy current, no allocate
                  data_wr_o       = '{en: 1'b1, way: lookup_i.way, line: req_f.line,
                                      word: req_f.word, data: apb_i.pwdata};
                  policy_update_o = 1'b1;
               end
               state_d = ST_LOOKUP;
            end
         end
         ST_ERROR: begin
            apb_o.pready  = 1'b1;
            apb_o.pslverr = 1'b1;
            state_d       = ST_IDLE;
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) state_q <= ST_IDLE;
      else         state_q <= state_d;
   end

   always_ff @(posedge clk_i) begin
      if (refill_start_o) victim_q <= victim_i;
   end

   // relies on the APB requester holding paddr and pwdata through the transfer
   mem_req_stable_a : assert property (@(posedge clk_i) disable iff (reset_i)
      mem_req_o.valid && !mem_resp_i.ack |=> $stable(mem_req_o));

endmodule

`default_nettype wire

// ==== cache_replacement_policy.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_replacement_policy import cache_pkg::*; #(
   parameter rep_policy_e REP_POLICY = REP_PLRU_TREE
) (
   input  logic      clk_i,
   input  logic      reset_i,
   input  logic      update_i,    // hit on line_i
   input  line_idx_t line_i,
   input  way_vec_t  way_hit_i,
   output way_vec_t  victim_o     // way to refill in line_i
);

   // bits per set: ranks, mru bits or tree nodes
   localparam int ST_W = (REP_POLICY == REP_LRU)      ? N_WAYS * WAY_W :
                         (REP_POLICY == REP_PLRU_MRU) ? N_WAYS : N_WAYS - 1;

   logic [ST_W-1:0] state_q [N_LINES];
   logic [ST_W-1:0] state_cur, state_nxt;

   assign state_cur = state_q[line_i];

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int l = 0; l < N_LINES; l++) begin
            state_q[l] <= '0;
         end
      end else if (update_i) begin
         state_q[line_i] <= state_nxt;
      end
   end

   if (REP_POLICY == REP_LRU) begin : g_lru
      logic [WAY_W-1:0] rank [N_WAYS];
      logic [WAY_W-1:0] hit_rank;

      always_comb begin
         hit_rank = '0;
         for (int w = 0; w < N_WAYS; w++) begin
            // all zero means untouched set, ranks start at the way index
            rank[w] = (|state_cur) ? state_cur[w*WAY_W +: WAY_W] : WAY_W'(w);
            if (way_hit_i[w]) hit_rank = rank[w];
         end
         for (int w = 0; w < N_WAYS; w++) begin
            if (way_hit_i[w])
               state_nxt[w*WAY_W +: WAY_W] = '1;                // most recent
            else if (rank[w] > hit_rank)
               state_nxt[w*WAY_W +: WAY_W] = rank[w] - 1'b1;
            else
               state_nxt[w*WAY_W +: WAY_W] = rank[w];
            victim_o[w] = (rank[w] == '0);                      // least recent
         end
      end
   end else if (REP_POLICY == REP_PLRU_MRU) begin : g_mru
      always_comb begin
         // once every bit would be set, start over from the hit way
         state_nxt = (&(state_cur | way_hit_i)) ? way_hit_i : (state_cur | way_hit_i);
         victim_o  = ~state_cur & (state_cur + 1'b1);           // lowest clear bit
      end
   end else begin : g_tree
      logic [WAY_W:0]   vic_node;   // heap numbering, root is 1
      logic [WAY_W:0]   upd_node;
      logic [WAY_W-1:0] hit_idx;

      always_comb begin
         vic_node = 1;
         for (int l = 0; l < WAY_W; l++) begin
            vic_node = {vic_node[WAY_W-1:0], state_cur[vic_node-1]};   // 0 goes left
         end
         victim_o = way_vec_t'(1) << vic_node[WAY_W-1:0];    // leaf minus N_WAYS

         hit_idx = '0;
         for (int w = 0; w < N_WAYS; w++) begin
            if (way_hit_i[w]) hit_idx = WAY_W'(w);
         end
         state_nxt = state_cur;
         upd_node  = 1;
         for (int l = 0; l < WAY_W; l++) begin
            state_nxt[upd_node-1] = ~hit_idx[WAY_W-1-l];   // point away from the hit
            upd_node = {upd_node[WAY_W-1:0], hit_idx[WAY_W-1-l]};
         end
      end
   end

   victim_onehot_a : assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot(victim_o));

   // the FSM only updates on a real hit from the tag array
   update_on_hit_a : assert property (@(posedge clk_i) disable iff (reset_i)
      update_i |-> $onehot(way_hit_i));

endmodule

`default_nettype wire

// ==== cache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_data_array import cache_pkg::*; (
   input  logic     clk_i,
   input  addr_t    addr_i,     // read address
   input  way_vec_t rd_way_i,   // one-hot hit way
   output word_t    rdata_o,
   input  data_wr_t wr_i
);

   addr_fields_t fields;
   word_t        mem_q [N_WAYS][N_LINES][LINE_WORDS];

   assign fields = addr_fields_t'(addr_i);

   // and-or mux over the ways, zero when nothing hits
   always_comb begin
      rdata_o = '0;
      for (int w = 0; w < N_WAYS; w++) begin
         if (rd_way_i[w]) rdata_o |= mem_q[w][fields.line][fields.word];
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_i.en) begin
         for (int w = 0; w < N_WAYS; w++) begin
            if (wr_i.way[w]) mem_q[w][wr_i.line][wr_i.word] <= wr_i.data;
         end
      end
   end

endmodule

`default_nettype wire

// ==== cache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tag_array import cache_pkg::*; (
   input  logic     clk_i,
   input  logic     reset_i,
   input  addr_t    addr_i,       // lookup and fill address
   input  logic     fill_i,       // write tag, set valid
   input  way_vec_t fill_way_i,   // one-hot way to fill
   output lookup_t  lookup_o
);

   addr_fields_t fields;
   tag_t         tag_q   [N_LINES][N_WAYS];
   way_vec_t     valid_q [N_LINES];
   way_vec_t     hit_vec;

   assign fields = addr_fields_t'(addr_i);

   // parallel compare against every way of the set
   always_comb begin
      for (int w = 0; w < N_WAYS; w++) begin
         hit_vec[w] = valid_q[fields.line][w] && (tag_q[fields.line][w] == fields.tag);
      end
   end

   assign lookup_o.hit = |hit_vec;
   assign lookup_o.way = hit_vec;

   // valid bits are control state
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int l = 0; l < N_LINES; l++) begin
            valid_q[l] <= '0;
         end
      end else if (fill_i) begin
         valid_q[fields.line] <= valid_q[fields.line] | fill_way_i;
      end
   end

   always_ff @(posedge clk_i) begin
      for (int w = 0; w < N_WAYS; w++) begin
         if (fill_i && fill_way_i[w]) tag_q[fields.line][w] <= fields.tag;
      end
   end

   // fills only follow a miss, so a tag never lands twice in a set
   hit_not_multi_a : assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(hit_vec));

   // the fill way comes from the policy and must name a single way
   fill_onehot_a : assert property (@(posedge clk_i) disable iff (reset_i)
      fill_i |-> $onehot(fill_way_i));

endmodule

`default_nettype wire

// ==== refill_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module refill_counter import cache_pkg::*; (
   input  logic      clk_i,
   input  logic      reset_i,
   input  logic      start_i,    // new refill, back to word 0
   input  logic      step_i,     // one word acknowledged
   output word_idx_t word_idx_o,
   output logic      last_o
);

   word_idx_t idx_q;
   logic      armed_q;   // a refill is in progress

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         idx_q   <= '0;
         armed_q <= 1'b0;
      end else if (start_i) begin
         idx_q   <= '0;
         armed_q <= 1'b1;
      end else if (step_i) begin
         idx_q <= idx_q + 1'b1;   // wraps to 0 after the last word
         if (last_o) armed_q <= 1'b0;
      end
   end

   assign word_idx_o = idx_q;
   assign last_o     = (idx_q == word_idx_t'(LINE_WORDS - 1));

   // the FSM only steps inside a refill it has started
   step_after_start_a : assert property (@(posedge clk_i) disable iff (reset_i)
      step_i |-> armed_q);

endmodule

`default_nettype wire

// ==== cache_pkg.sv ====
`default_nettype none

`include "cache_config.svh"

package cache_pkg;

   localparam int N_WAYS     = `CACHE_N_WAYS;
   localparam int WAY_W      = $clog2(N_WAYS);        // way index width
   localparam int LINE_W     = `CACHE_NLINES_W;
   localparam int N_LINES    = 1 << LINE_W;
   localparam int WORD_OFF_W = `CACHE_WORD_OFF_W;
   localparam int LINE_WORDS = 1 << WORD_OFF_W;
   localparam int ADDR_W     = `CACHE_ADDR_W;
   localparam int DATA_W     = `CACHE_DATA_W;
   localparam int BYTE_OFF_W = $clog2(DATA_W / 8);
   localparam int TAG_W      = ADDR_W - LINE_W - WORD_OFF_W - BYTE_OFF_W;

   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [DATA_W-1:0]     word_t;
   typedef logic [LINE_W-1:0]     line_idx_t;
   typedef logic [WORD_OFF_W-1:0] word_idx_t;
   typedef logic [TAG_W-1:0]      tag_t;
   typedef logic [N_WAYS-1:0]     way_vec_t;   // one bit per way

   // byte address split into its cache fields, msb first
   typedef struct packed {
      tag_t                  tag;
      line_idx_t             line;
      word_idx_t             word;
      logic [BYTE_OFF_W-1:0] byte_off;
   } addr_fields_t;

   typedef struct packed {
      logic     hit;
      way_vec_t way;   // one-hot on a hit, zero otherwise
   } lookup_t;

   typedef struct packed {
      logic      en;
      way_vec_t  way;
      line_idx_t line;
      word_idx_t word;
      word_t     data;
   } data_wr_t;

   typedef struct packed {
      logic  valid;
      logic  we;
      addr_t addr;    // always word aligned
      word_t wdata;
   } mem_req_t;

   typedef struct packed {
      logic  ack;
      word_t rdata;
   } mem_resp_t;

   typedef enum logic [2:0] {ST_IDLE, ST_LOOKUP, ST_REFILL, ST_WRITE, ST_ERROR} ctrl_state_e;
   typedef enum logic [1:0] {REP_LRU, REP_PLRU_MRU, REP_PLRU_TREE} rep_policy_e;

endpackage

`default_nettype wire

// ==== apb_pkg.sv ====
`default_nettype none

`include "cache_config.svh"

package apb_pkg;

   // requester side of an APB transfer
   typedef struct packed {
      logic                     psel;
      logic                     penable;
      logic                     pwrite;
      logic [`CACHE_ADDR_W-1:0] paddr;
      logic [`CACHE_DATA_W-1:0] pwdata;
   } apb_req_t;

   // completer side, pslverr and prdata only count while pready is high
   typedef struct packed {
      logic                     pready;
      logic                     pslverr;
      logic [`CACHE_DATA_W-1:0] prdata;
   } apb_resp_t;

endpackage

`default_nettype wire

// ==== cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// cache geometry
`define CACHE_N_WAYS      4   // associativity
`define CACHE_NLINES_W    3   // 8 sets
`define CACHE_WORD_OFF_W  2   // 4 words per line

// bus widths
`define CACHE_ADDR_W      16  // byte address
`define CACHE_DATA_W      32

// victim selection, one of the rep_policy_e literals in cache_pkg
`define CACHE_REP_POLICY  REP_PLRU_TREE

`endif
